/* Bender.yml */
package:
  name: rv_core_pipelined

sources:
  - rv_pkg.sv
  - rv_word_ram.sv
  - rv_regfile.sv
  - rv_decoder.sv
  - rv_alu.sv
  - rv_hazard_unit.sv
  - rv_core_pipelined.sv
  - target: simulation
    files:
      - tb_rv_core.sv

/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t i_op,
    input  rv_pkg::word_t   i_a,
    input  rv_pkg::word_t   i_b,
    input  logic [2:0]      i_funct3,
    output rv_pkg::word_t   o_result,
    output logic            o_br_cond
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    // low five bits of b, reg or imm shift amount
    assign shamt = i_b[4:0];
    assign eq    = (i_a == i_b);
    assign lt    = ($signed(i_a) < $signed(i_b));
    assign ltu   = (i_a < i_b);

    always_comb
    begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SLT:    o_result = {31'b0, lt};
            ALU_SLTU:   o_result = {31'b0, ltu};
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SRL:    o_result = i_a >> shamt;
            // sign fill from bit 31
            ALU_SRA:    o_result = $signed(i_a) >>> shamt;
            ALU_OR:     o_result = i_a | i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // branch condition by funct3
    always_comb
    begin
        case (i_funct3)
            3'b000:  o_br_cond = eq;
            3'b001:  o_br_cond = !eq;
            3'b100:  o_br_cond = lt;
            3'b101:  o_br_cond = !lt;
            // unsigned branches not in this subset
            default: o_br_cond = 1'b0;
        endcase
    end

endmodule

/* rv_core_pipelined.sv */
`timescale 1ns/1ps

module rv_core_pipelined (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_run,
    input  logic                         i_load_valid,
    input  logic [rv_pkg::MEM_IDX_W-1:0] i_load_addr,
    input  rv_pkg::word_t                i_load_data,
    output rv_pkg::word_t                o_pc,
    output logic                         o_wb_valid,
    output rv_pkg::reg_addr_t            o_wb_rd,
    output rv_pkg::word_t                o_wb_data
);
    import rv_pkg::*;

    // fetch
    word_t     pc;
    word_t     fetch_instr;
    // if/id
    logic      if_id_valid;
    word_t     if_id_pc;
    word_t     if_id_instr;
    // decode
    alu_op_t   dec_alu_op;
    logic      dec_op1_pc;
    logic      dec_op2_imm;
    logic      dec_reg_we;
    logic      dec_mem_read;
    logic      dec_mem_write;
    br_type_t  dec_br_type;
    logic      dec_is_jalr;
    wb_sel_t   dec_wb_sel;
    word_t     dec_imm;
    word_t     rf_rs1_data;
    word_t     rf_rs2_data;
    // id/ex
    logic      id_ex_valid;
    word_t     id_ex_pc;
    word_t     id_ex_instr;
    word_t     id_ex_rs1_data;
    word_t     id_ex_rs2_data;
    word_t     id_ex_imm;
    alu_op_t   id_ex_alu_op;
    logic      id_ex_op1_pc;
    logic      id_ex_op2_imm;
    logic      id_ex_reg_we;
    logic      id_ex_mem_read;
    logic      id_ex_mem_write;
    br_type_t  id_ex_br_type;
    logic      id_ex_is_jalr;
    wb_sel_t   id_ex_wb_sel;
    // execute
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      hz_stall;
    logic      stall;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      br_cond;
    word_t     ret_addr;
    word_t     br_target;
    logic      redirect;
    // ex/mem
    logic      ex_mem_valid;
    word_t     ex_mem_alu;
    word_t     ex_mem_pc4;
    word_t     ex_mem_store_data;
    reg_addr_t ex_mem_rd;
    logic      ex_mem_reg_we;
    logic      ex_mem_mem_read;
    logic      ex_mem_mem_write;
    wb_sel_t   ex_mem_wb_sel;
    word_t     ex_mem_fwd;
    word_t     dmem_rdata;
    // mem/wb
    logic      mem_wb_valid;
    word_t     mem_wb_alu;
    word_t     mem_wb_pc4;
    word_t     mem_wb_load;
    reg_addr_t mem_wb_rd;
    logic      mem_wb_reg_we;
    wb_sel_t   mem_wb_wb_sel;
    word_t     wb_data;
    logic      wb_we;

    // operand source pick
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_EX_MEM: return mem_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    //////////////////////////////
    // fetch

    // loader owns the write side only while halted
    rv_word_ram u_imem (
        .clk     (clk),
        .i_we    (i_load_valid && !i_run),
        .i_waddr (i_load_addr),
        .i_wdata (i_load_data),
        .i_raddr (pc[MEM_IDX_W+1:2]),
        .o_rdata (fetch_instr)
    );

    //////////////////////////////
    // decode

    rv_decoder u_decoder (
        .i_instr     (if_id_instr),
        .o_alu_op    (dec_alu_op),
        .o_op1_pc    (dec_op1_pc),
        .o_op2_imm   (dec_op2_imm),
        .o_reg_we    (dec_reg_we),
        .o_mem_read  (dec_mem_read),
        .o_mem_write (dec_mem_write),
        .o_br_type   (dec_br_type),
        .o_is_jalr   (dec_is_jalr),
        .o_wb_sel    (dec_wb_sel),
        .o_imm       (dec_imm)
    );

    // written from writeback, read in decode
    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (if_id_instr[19:15]),
        .i_rs2      (if_id_instr[24:20]),
        .i_rd       (mem_wb_rd),
        .i_we       (wb_we),
        .i_wdata    (wb_data),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    // all producer flags qualified by stage valid
    rv_hazard_unit u_hazard (
        .i_ex_rs1      (id_ex_instr[19:15]),
        .i_ex_rs2      (id_ex_instr[24:20]),
        .i_mem_rd      (ex_mem_rd),
        .i_wb_rd       (mem_wb_rd),
        .i_id_rs1      (if_id_instr[19:15]),
        .i_id_rs2      (if_id_instr[24:20]),
        .i_mem_reg_we  (ex_mem_valid && ex_mem_reg_we),
        .i_mem_is_load (ex_mem_mem_read),
        .i_wb_reg_we   (mem_wb_valid && mem_wb_reg_we),
        .i_ex_is_load  (id_ex_valid && id_ex_mem_read),
        .i_ex_rd       (id_ex_instr[11:7]),
        .o_fwd_a       (fwd_a),
        .o_fwd_b       (fwd_b),
        .o_stall       (hz_stall)
    );

    // empty decode slot never stalls
    assign stall = hz_stall && if_id_valid;

    //////////////////////////////
    // execute

    assign op_a  = fwd_mux(fwd_a, id_ex_rs1_data, ex_mem_fwd, wb_data);
    assign op_b  = fwd_mux(fwd_b, id_ex_rs2_data, ex_mem_fwd, wb_data);
    assign alu_a = id_ex_op1_pc  ? id_ex_pc  : op_a;
    assign alu_b = id_ex_op2_imm ? id_ex_imm : op_b;

    rv_alu u_alu (
        .i_op      (id_ex_alu_op),
        .i_a       (alu_a),
        .i_b       (alu_b),
        .i_funct3  (id_ex_instr[14:12]),
        .o_result  (alu_result),
        .o_br_cond (br_cond)
    );

    assign ret_addr  = id_ex_pc + 32'd4;
    // jalr target is rs1 + imm from the alu, bit 0 cleared
    assign br_target = id_ex_is_jalr ? {alu_result[31:1], 1'b0} : id_ex_pc + id_ex_imm;
    // not-taken prediction, fix up here
    assign redirect  = id_ex_valid &&
                       ((id_ex_br_type == BR_JUMP) ||
                        ((id_ex_br_type == BR_COND) && br_cond));

    //////////////////////////////
    // memory

    // jal/jalr carry the return address, loads are never forwarded from here
    assign ex_mem_fwd = (ex_mem_wb_sel == WB_RET_ADDR) ? ex_mem_pc4 : ex_mem_alu;

    rv_word_ram u_dmem (
        .clk     (clk),
        .i_we    (ex_mem_valid && ex_mem_mem_write),
        .i_waddr (ex_mem_alu[MEM_IDX_W+1:2]),
        .i_wdata (ex_mem_store_data),
        .i_raddr (ex_mem_alu[MEM_IDX_W+1:2]),
        .o_rdata (dmem_rdata)
    );

    //////////////////////////////
    // writeback

    always_comb
    begin
        case (mem_wb_wb_sel)
            WB_LOAD:     wb_data = mem_wb_load;
            WB_RET_ADDR: wb_data = mem_wb_pc4;
            default:     wb_data = mem_wb_alu;
        endcase
    end

    // x0 writes vanish here, strobe included
    assign wb_we      = mem_wb_valid && mem_wb_reg_we && (mem_wb_rd != '0);
    assign o_wb_valid = wb_we;
    assign o_wb_rd    = mem_wb_rd;
    assign o_wb_data  = wb_data;
    assign o_pc       = pc;

    //////////////////////////////
    // pc and valid bits

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc           <= RESET_PC;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end
        else if (!i_run)
        begin
            // halted, restart from the top
            pc           <= RESET_PC;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end
        else
        begin
            if (redirect)
            begin
                pc <= br_target;
            end
            else if (!stall)
            begin
                pc <= pc + 32'd4;
            end
            // redirect kills the two younger slots
            // stall holds if/id and drops a bubble into ex
            if (redirect)
            begin
                if_id_valid <= 1'b0;
            end
            else if (!stall)
            begin
                if_id_valid <= 1'b1;
            end
            id_ex_valid  <= if_id_valid && !stall && !redirect;
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    // stage payloads, meaningful only under their valid bit
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            if_id_pc    <= pc;
            if_id_instr <= fetch_instr;
        end
        id_ex_pc          <= if_id_pc;
        id_ex_instr       <= if_id_instr;
        id_ex_rs1_data    <= rf_rs1_data;
        id_ex_rs2_data    <= rf_rs2_data;
        id_ex_imm         <= dec_imm;
        id_ex_alu_op      <= dec_alu_op;
        id_ex_op1_pc      <= dec_op1_pc;
        id_ex_op2_imm     <= dec_op2_imm;
        id_ex_reg_we      <= dec_reg_we;
        id_ex_mem_read    <= dec_mem_read;
        id_ex_mem_write   <= dec_mem_write;
        id_ex_br_type     <= dec_br_type;
        id_ex_is_jalr     <= dec_is_jalr;
        id_ex_wb_sel      <= dec_wb_sel;
        ex_mem_alu        <= alu_result;
        ex_mem_pc4        <= ret_addr;
        // store data after forwarding
        ex_mem_store_data <= op_b;
        ex_mem_rd         <= id_ex_instr[11:7];
        ex_mem_reg_we     <= id_ex_reg_we;
        ex_mem_mem_read   <= id_ex_mem_read;
        ex_mem_mem_write  <= id_ex_mem_write;
        ex_mem_wb_sel     <= id_ex_wb_sel;
        mem_wb_alu        <= ex_mem_alu;
        mem_wb_pc4        <= ex_mem_pc4;
        mem_wb_load       <= dmem_rdata;
        mem_wb_rd         <= ex_mem_rd;
        mem_wb_reg_we     <= ex_mem_reg_we;
        mem_wb_wb_sel     <= ex_mem_wb_sel;
    end

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::word_t    i_instr,
    output rv_pkg::alu_op_t  o_alu_op,
    output logic             o_op1_pc,
    output logic             o_op2_imm,
    output logic             o_reg_we,
    output logic             o_mem_read,
    output logic             o_mem_write,
    output rv_pkg::br_type_t o_br_type,
    output logic             o_is_jalr,
    output rv_pkg::wb_sel_t  o_wb_sel,
    output rv_pkg::word_t    o_imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    // funct7 bit 5, sub and sra
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // funct3 to alu code, shared by op and op-imm
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign alt    = i_instr[30];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                    i_instr[20], i_instr[30:21], 1'b0};

    always_comb
    begin
        // defaults give a nop
        o_alu_op    = ALU_ADD;
        o_op1_pc    = 1'b0;
        o_op2_imm   = 1'b0;
        o_reg_we    = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_br_type   = BR_NONE;
        o_is_jalr   = 1'b0;
        o_wb_sel    = WB_ALU;
        o_imm       = imm_i;
        case (opcode)
            OPCODE_OP:
            begin
                o_alu_op = arith_op(funct3, alt);
                o_reg_we = 1'b1;
            end
            OPCODE_OP_IMM:
            begin
                // bit 30 only matters for srai, addi never subtracts
                o_alu_op  = arith_op(funct3, alt && (funct3 == 3'b101));
                o_op2_imm = 1'b1;
                o_reg_we  = 1'b1;
            end
            OPCODE_LUI:
            begin
                o_alu_op  = ALU_PASS_B;
                o_op2_imm = 1'b1;
                o_reg_we  = 1'b1;
                o_imm     = imm_u;
            end
            OPCODE_LOAD:
            begin
                // lw only, address is rs1 + imm
                o_op2_imm  = 1'b1;
                o_reg_we   = 1'b1;
                o_mem_read = 1'b1;
                o_wb_sel   = WB_LOAD;
            end
            OPCODE_STORE:
            begin
                o_op2_imm   = 1'b1;
                o_mem_write = 1'b1;
                o_imm       = imm_s;
            end
            OPCODE_BRANCH:
            begin
                // beq/bne compare equal, blt/bge compare signed
                o_alu_op  = funct3[2] ? ALU_SLT : ALU_SUB;
                o_br_type = BR_COND;
                o_imm     = imm_b;
            end
            OPCODE_JAL:
            begin
                // alu forms pc + imm as well, target comes from its own adder
                o_op1_pc  = 1'b1;
                o_op2_imm = 1'b1;
                o_reg_we  = 1'b1;
                o_br_type = BR_JUMP;
                o_wb_sel  = WB_RET_ADDR;
                o_imm     = imm_j;
            end
            OPCODE_JALR:
            begin
                // alu gives rs1 + imm, top clears bit 0
                o_op2_imm = 1'b1;
                o_reg_we  = 1'b1;
                o_br_type = BR_JUMP;
                o_is_jalr = 1'b1;
                o_wb_sel  = WB_RET_ADDR;
            end
            default:
            begin
                // anything else retires silently
                o_reg_we = 1'b0;
            end
        endcase
    end

endmodule

/* rv_hazard_unit.sv */
`timescale 1ns/1ps

module rv_hazard_unit (
    input  rv_pkg::reg_addr_t i_ex_rs1,
    input  rv_pkg::reg_addr_t i_ex_rs2,
    input  rv_pkg::reg_addr_t i_mem_rd,
    input  rv_pkg::reg_addr_t i_wb_rd,
    input  rv_pkg::reg_addr_t i_id_rs1,
    input  rv_pkg::reg_addr_t i_id_rs2,
    input  logic              i_mem_reg_we,
    input  logic              i_mem_is_load,
    input  logic              i_wb_reg_we,
    input  logic              i_ex_is_load,
    input  rv_pkg::reg_addr_t i_ex_rd,
    output rv_pkg::fwd_sel_t  o_fwd_a,
    output rv_pkg::fwd_sel_t  o_fwd_b,
    output logic              o_stall
);
    import rv_pkg::*;

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // ex/mem can forward unless it is a load, data not back yet
    assign mem_fwd_ok = i_mem_reg_we && !i_mem_is_load && (i_mem_rd != '0);
    // mem/wb forwards any write, loads included
    assign wb_fwd_ok  = i_wb_reg_we && (i_wb_rd != '0);

    // nearer producer first
    assign o_fwd_a = (mem_fwd_ok && (i_mem_rd == i_ex_rs1)) ? FWD_EX_MEM :
                     (wb_fwd_ok  && (i_wb_rd  == i_ex_rs1)) ? FWD_MEM_WB : FWD_NONE;
    assign o_fwd_b = (mem_fwd_ok && (i_mem_rd == i_ex_rs2)) ? FWD_EX_MEM :
                     (wb_fwd_ok  && (i_wb_rd  == i_ex_rs2)) ? FWD_MEM_WB : FWD_NONE;

    // load in ex feeding decode, one bubble
    // after it the load sits in mem/wb and forwards from there
    // i-type rs2 field may match too, costs a spare bubble only
    assign o_stall = i_ex_is_load && (i_ex_rd != '0) &&
                     ((i_ex_rd == i_id_rs1) || (i_ex_rd == i_id_rs2));

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // data and address word
    typedef logic [31:0] word_t;
    // register index
    typedef logic [4:0]  reg_addr_t;
    // alu operation code
    typedef logic [3:0]  alu_op_t;
    // control transfer kind
    typedef logic [1:0]  br_type_t;
    // writeback source
    typedef logic [1:0]  wb_sel_t;
    // operand forward source
    typedef logic [1:0]  fwd_sel_t;

    //////////////////////////////
    // alu codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // operand b straight through, for lui
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // control transfer kinds
    localparam br_type_t BR_NONE = 2'd0;
    localparam br_type_t BR_COND = 2'd1;
    localparam br_type_t BR_JUMP = 2'd2;

    // writeback sources
    localparam wb_sel_t WB_ALU      = 2'd0;
    localparam wb_sel_t WB_LOAD     = 2'd1;
    localparam wb_sel_t WB_RET_ADDR = 2'd2;

    // forward sources, nearer stage wins
    localparam fwd_sel_t FWD_NONE   = 2'd0;
    localparam fwd_sel_t FWD_EX_MEM = 2'd1;
    localparam fwd_sel_t FWD_MEM_WB = 2'd2;

    //////////////////////////////
    // rv32i major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // memories in words
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    // word index wide enough for the larger memory
    localparam int MEM_IDX_W  = $clog2((IMEM_DEPTH > DMEM_DEPTH) ? IMEM_DEPTH : DMEM_DEPTH);

    // first fetch address after reset or run
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  rv_pkg::reg_addr_t i_rd,
    input  logic              i_we,
    input  rv_pkg::word_t     i_wdata,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);
    import rv_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 reads zero
    // same-cycle write bypasses to the read, so decode sees writeback
    assign o_rs1_data = (i_rs1 == '0)                 ? '0      :
                        (i_we && (i_rd == i_rs1))     ? i_wdata : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0)                 ? '0      :
                        (i_we && (i_rd == i_rs2))     ? i_wdata : regs[i_rs2];

endmodule

/* rv_stimulus.mem */
// all fields hex: word count, program words, expected entry count
// then one expected write per line: rd value, in retirement order
20
00500093 // 00 addi x1, x0, 5
FFD00113 // 01 addi x2, x0, -3
002081B3 // 02 add  x3, x1, x2   fwd from ex/mem and mem/wb
40118233 // 03 sub  x4, x3, x1
40125293 // 04 srai x5, x4, 1    negative value
01C25313 // 05 srli x6, x4, 28
001123B3 // 06 slt  x7, x2, x1
00113433 // 07 sltu x8, x2, x1
123454B7 // 08 lui  x9, 0x12345
6784E513 // 09 ori  x10, x9, 0x678
001545B3 // 0a xor  x11, x10, x1
0065F633 // 0b and  x12, x11, x6
00409693 // 0c slli x13, x1, 4
00A02423 // 0d sw   x10, 8(x0)
00802703 // 0e lw   x14, 8(x0)
00170793 // 0f addi x15, x14, 1  load-use stall
00708013 // 10 addi x0, x1, 7    no strobe
00100833 // 11 add  x16, x0, x1
00108463 // 12 beq  x1, x1, +8   taken
06300893 // 13 addi x17, x0, 99  skipped
00109463 // 14 bne  x1, x1, +8   not taken
00100913 // 15 addi x18, x0, 1
00114463 // 16 blt  x2, x1, +8   taken
00200993 // 17 addi x19, x0, 2   skipped
0020D463 // 18 bge  x1, x2, +8   taken
00300993 // 19 addi x19, x0, 3   skipped
00800A6F // 1a jal  x20, +8
00400A93 // 1b addi x21, x0, 4   skipped
00CA0B67 // 1c jalr x22, 12(x20)
00500A93 // 1d addi x21, x0, 5   skipped
001A0B93 // 1e addi x23, x20, 1
0000006F // 1f jal  x0, 0        self loop
14
01 00000005
02 FFFFFFFD
03 00000002
04 FFFFFFFD
05 FFFFFFFE
06 0000000F
07 00000001
08 00000000
09 12345000
0A 12345678
0B 1234567D
0C 0000000D
0D 00000050
0E 12345678
0F 12345679
10 00000005
12 00000001
14 0000006C
16 00000074
17 0000006D

/* rv_word_ram.sv */
`timescale 1ns/1ps

module rv_word_ram (
    input  logic                         clk,
    input  logic                         i_we,
    input  logic [rv_pkg::MEM_IDX_W-1:0] i_waddr,
    input  rv_pkg::word_t                i_wdata,
    input  logic [rv_pkg::MEM_IDX_W-1:0] i_raddr,
    output rv_pkg::word_t                o_rdata
);
    import rv_pkg::*;

    // one word per index
    word_t mem [2**MEM_IDX_W];

    // write on the rising edge
    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // combinational read
    // a store and a later load see the stored word on the next cycle
    assign o_rdata = mem[i_raddr];

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    // cycles allowed between two strobes
    localparam int WAIT_LIMIT  = 200;
    // quiet window once the program sits in its self loop
    localparam int TAIL_CYCLES = 40;
    localparam int STIM_DEPTH  = 512;

    logic                 clk;
    logic                 rst_n;
    logic                 i_run;
    logic                 i_load_valid;
    logic [MEM_IDX_W-1:0] i_load_addr;
    word_t                i_load_data;
    word_t                o_pc;
    logic                 o_wb_valid;
    reg_addr_t            o_wb_rd;
    word_t                o_wb_data;

    // raw data file image
    word_t     stim [STIM_DEPTH];
    // retired writes seen at the port in arrival order
    reg_addr_t seen_rd [$];
    word_t     seen_data [$];
    int        strobe_count;
    int        check_count;
    int        error_count;
    int        timeout_count;
    int        prog_words;
    int        exp_entries;
    int        base;
    logic      got;
    reg_addr_t got_rd;
    word_t     got_data;

    rv_core_pipelined UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_run        (i_run),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .o_pc         (o_pc),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    // 4 ns period
    always #2 clk = ~clk;

    //////////////////////////////
    // writeback monitor

    // mid-cycle sample of a one-cycle strobe
    always @(negedge clk)
    begin
        if (rst_n && o_wb_valid)
        begin
            seen_rd.push_back(o_wb_rd);
            seen_data.push_back(o_wb_data);
            strobe_count++;
        end
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // block until the monitor holds an entry or the limit runs out
    task automatic wait_for_strobe(input int idx, output logic ok);
        int cycles;
        cycles = 0;
        while ((seen_rd.size() == 0) && (cycles < WAIT_LIMIT))
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (seen_rd.size() != 0);
        if (!ok)
        begin
            timeout_count++;
            $display("timeout: writeback entry %0d did not arrive within %0d cycles",
                     idx, WAIT_LIMIT);
        end
    endtask

    //////////////////////////////
    // main sequence

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        i_run         = 1'b0;
        i_load_valid  = 1'b0;
        i_load_addr   = '0;
        i_load_data   = '0;
        strobe_count  = 0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;

        // word count, program, entry count, then rd/value pairs
        $readmemh("rv_stimulus.mem", stim);
        prog_words  = stim[0];
        exp_entries = stim[prog_words + 1];
        base        = prog_words + 2;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // fetch starts from address zero
        check_value("reset pc", 32'h0000_0000, o_pc);
        check_value("reset strobe", 32'd0, {31'd0, o_wb_valid});

        // program goes in while the core is halted
        for (int k = 0; k < prog_words; k++)
        begin
            @(posedge clk);
            i_load_valid <= 1'b1;
            i_load_addr  <= k[MEM_IDX_W-1:0];
            i_load_data  <= stim[k + 1];
        end
        @(posedge clk);
        i_load_valid <= 1'b0;
        @(posedge clk);
        i_run <= 1'b1;

        // retirement order must match the file
        for (int k = 0; (k < exp_entries) && (timeout_count == 0); k++)
        begin
            wait_for_strobe(k, got);
            if (got)
            begin
                got_rd   = seen_rd.pop_front();
                got_data = seen_data.pop_front();
                check_value($sformatf("wb %0d rd", k), stim[base + 2 * k], {27'd0, got_rd});
                check_value($sformatf("wb %0d data", k), stim[base + 2 * k + 1], got_data);
            end
        end

        // nothing else may retire once the self loop is reached
        repeat (TAIL_CYCLES) @(posedge clk);
        check_value("strobe count", exp_entries, strobe_count);
        check_value("late strobes", 32'd0, seen_rd.size());

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
rv_pkg.sv
rv_word_ram.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_hazard_unit.sv
rv_core_pipelined.sv
tb_rv_core.sv
